// File: files.f
fight_pkg.sv
attack_decode.sv
hit_tracker.sv
match_fsm.sv
hud_overlay.sv
fight_core.sv
fight_core_tb.sv

// File: Bender.yml
package:
  name: fight_core

sources:
  - fight_pkg.sv
  - attack_decode.sv
  - hit_tracker.sv
  - match_fsm.sv
  - hud_overlay.sv
  - fight_core.sv
  - target: test
    files:
      - fight_core_tb.sv

// File: fight_core_tb.sv
module fight_core_tb import fight_pkg::*; ();

  localparam int       HIT_DAMAGE  = 12;
  localparam buttons_t PRESS_A     = buttons_t'(1 << BTN_A);
  localparam buttons_t PRESS_START = buttons_t'(1 << BTN_START);
  localparam coord_t   IDLE_PIXEL  = 10'd300;

  // One row of the stimulus table with the outputs expected after it
  typedef struct packed {
    buttons_t     b1;
    buttons_t     b2;
    coord_t       x1;
    coord_t       y1;
    coord_t       x2;
    coord_t       y2;
    logic         tick;
    coord_t       col;
    coord_t       row;
    match_state_t state;
    damage_t      d1;
    damage_t      d2;
    stock_t       s1;
    stock_t       s2;
    rgb_t         rgb;
  } step_t;

  logic         clk_out;
  logic         rst_n;
  logic         frame_tick;
  buttons_t     buttons1;
  buttons_t     buttons2;
  coord_t       x1;
  coord_t       y1;
  coord_t       x2;
  coord_t       y2;
  coord_t       col;
  coord_t       row;
  match_state_t match_state;
  damage_t      damage1;
  damage_t      damage2;
  stock_t       stocks1;
  stock_t       stocks2;
  rgb_t         hud_rgb;

  step_t        steps[$];
  match_state_t exp_state;
  damage_t      exp_d1;
  damage_t      exp_d2;
  stock_t       exp_s1;
  stock_t       exp_s2;
  integer       seed = 32'hf8539c90;
  int           errors;
  int           checks;

  fight_core fight_core_inst (
    .clk_out    (clk_out),
    .rst_n      (rst_n),
    .frame_tick (frame_tick),
    .buttons1   (buttons1),
    .buttons2   (buttons2),
    .x1         (x1),
    .y1         (y1),
    .x2         (x2),
    .y2         (y2),
    .col        (col),
    .row        (row),
    .match_state(match_state),
    .damage1    (damage1),
    .damage2    (damage2),
    .stocks1    (stocks1),
    .stocks2    (stocks2),
    .hud_rgb    (hud_rgb)
  );

  always #50 clk_out = ~clk_out;

  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk_out);
    rst_n <= 1'b1;
  end

  task automatic push_step(input buttons_t b1, input buttons_t b2, input logic near,
                           input logic tick, input coord_t c, input coord_t r, input rgb_t rgb);
    coord_t px1;
    coord_t py1;
    coord_t px2;
    coord_t py2;
    if (near) begin
      px1 = 10'd100;
      py1 = 10'd200;
      px2 = 10'd120;
      py2 = 10'd200;
    end else begin
      // Second box starts past the far edge of the first
      px1 = coord_t'($unsigned($random(seed)) % 200);
      px2 = px1 + 10'd50 + coord_t'($unsigned($random(seed)) % 200);
      py1 = coord_t'($unsigned($random(seed)) % 400);
      py2 = coord_t'($unsigned($random(seed)) % 400);
    end
    steps.push_back('{b1, b2, px1, py1, px2, py2, tick, c, r,
                      exp_state, exp_d1, exp_d2, exp_s1, exp_s2, rgb});
  endtask

  task automatic plain_step(input buttons_t b1, input buttons_t b2, input logic near,
                            input logic tick);
    push_step(b1, b2, near, tick, IDLE_PIXEL, IDLE_PIXEL, RGB_BLACK);
  endtask

  task automatic land_hit(inout damage_t dmg, inout stock_t stk);
    if (int'(dmg) + HIT_DAMAGE >= int'(DAMAGE_KO)) begin
      // KO empties the meter and costs a stock
      dmg = '0;
      stk = stk - 1'b1;
    end else begin
      dmg = dmg + damage_t'(HIT_DAMAGE);
    end
  endtask

  // Press A on a tick, then gap more ticks with A held or released
  task automatic strike_seq(input int who, input logic near, input logic lands,
                            input logic hold, input int gap);
    buttons_t rest;
    rest = hold ? PRESS_A : '0;
    plain_step((who == 1) ? PRESS_A : '0, (who == 2) ? PRESS_A : '0, near, 1'b1);
    for (int k = 0; k < gap; k++) begin
      plain_step((who == 1) ? rest : '0, (who == 2) ? rest : '0, near, 1'b1);
      // New damage is visible two cycles after the press tick
      if (k == 0 && lands) begin
        if (who == 1) begin
          land_hit(exp_d2, exp_s2);
        end else begin
          land_hit(exp_d1, exp_s1);
        end
      end
      if (k == 1 && (exp_s1 == '0 || exp_s2 == '0)) begin
        exp_state = MATCH_OVER;
      end
    end
  endtask

  task automatic build_table();
    exp_state = MATCH_START;
    exp_d1    = '0;
    exp_d2    = '0;
    exp_s1    = START_STOCKS;
    exp_s2    = START_STOCKS;
    push_step('0, '0, 1'b1, 1'b0, P1_BAR_X, BAR_Y, RGB_BLACK);
    // Unplugged pad reads all ones
    plain_step('1, '0, 1'b1, 1'b1);
    plain_step('0, '0, 1'b1, 1'b0);
    plain_step('0, PRESS_START, 1'b1, 1'b0);
    exp_state = MATCH_PLAYING;
    push_step('0, '0, 1'b1, 1'b0, P1_BAR_X, BAR_Y, RGB_WHITE);
    push_step('0, '0, 1'b1, 1'b0, 10'd121, 10'd20, RGB_GREEN);
    push_step('0, '0, 1'b1, 1'b0, 10'd122, 10'd20, RGB_WHITE);
    strike_seq(1, 1'b1, 1'b1, 1'b0, 12);
    // Held A strikes once only, even after cooldown and hitstun run out
    strike_seq(1, 1'b1, 1'b1, 1'b1, 20);
    plain_step('0, '0, 1'b1, 1'b1);
    // Miss, then a press inside the cooldown with the boxes together
    strike_seq(1, 1'b0, 1'b0, 1'b0, 1);
    strike_seq(1, 1'b1, 1'b0, 1'b0, 11);
    strike_seq(1, 1'b0, 1'b0, 1'b0, 12);
    // Second strike arrives while the target is stunned
    strike_seq(1, 1'b1, 1'b1, 1'b0, 8);
    strike_seq(1, 1'b1, 1'b0, 1'b0, 12);
    strike_seq(2, 1'b1, 1'b1, 1'b0, 12);
    push_step('0, '0, 1'b1, 1'b0, 10'd109, 10'd20, RGB_GREEN);
    push_step('0, '0, 1'b1, 1'b0, 10'd110, 10'd20, RGB_WHITE);
    push_step('0, '0, 1'b1, 1'b0, 10'd552, 10'd35, RGB_RED);
    while (exp_s2 == START_STOCKS) begin
      strike_seq(1, 1'b1, 1'b1, 1'b0, 12);
    end
    push_step('0, '0, 1'b1, 1'b0, 10'd552, 10'd35, RGB_BLACK);
    push_step('0, '0, 1'b1, 1'b0, 10'd537, 10'd35, RGB_RED);
    while (exp_state == MATCH_PLAYING) begin
      strike_seq(1, 1'b1, 1'b1, 1'b0, 12);
    end
    // Game over ignores ticks and presses
    strike_seq(1, 1'b1, 1'b0, 1'b0, 12);
    push_step('0, '0, 1'b1, 1'b0, P1_BAR_X, BAR_Y, RGB_WHITE);
    plain_step(PRESS_START, '0, 1'b1, 1'b0);
    exp_state = MATCH_PLAYING;
    exp_d1    = '0;
    exp_d2    = '0;
    exp_s1    = START_STOCKS;
    exp_s2    = START_STOCKS;
    plain_step('0, '0, 1'b1, 1'b0);
    strike_seq(1, 1'b1, 1'b1, 1'b0, 12);
  endtask

  task automatic check_state(input match_state_t exp, input match_state_t got, input int idx);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: step %0d match_state expected %0d got %0d", $time, idx, exp, got);
    end
  endtask

  task automatic check_damage(input damage_t exp, input damage_t got, input int idx,
                              input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: step %0d %s expected %0d got %0d", $time, idx, what, exp, got);
    end
  endtask

  task automatic check_stocks(input stock_t exp, input stock_t got, input int idx,
                              input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: step %0d %s expected %0d got %0d", $time, idx, what, exp, got);
    end
  endtask

  task automatic check_rgb(input rgb_t exp, input rgb_t got, input int idx);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: step %0d hud_rgb expected %b got %b", $time, idx, exp, got);
    end
  endtask

  task automatic apply_steps();
    step_t s;
    for (int i = 0; i < steps.size(); i++) begin
      s = steps[i];
      @(posedge clk_out);
      buttons1   <= s.b1;
      buttons2   <= s.b2;
      x1         <= s.x1;
      y1         <= s.y1;
      x2         <= s.x2;
      y2         <= s.y2;
      frame_tick <= s.tick;
      col        <= s.col;
      row        <= s.row;
      // Registered outputs reflect the previous step, hud_rgb this one
      @(negedge clk_out);
      check_state(s.state, match_state, i);
      check_damage(s.d1, damage1, i, "damage1");
      check_damage(s.d2, damage2, i, "damage2");
      check_stocks(s.s1, stocks1, i, "stocks1");
      check_stocks(s.s2, stocks2, i, "stocks2");
      check_rgb(s.rgb, hud_rgb, i);
    end
  endtask

  initial begin
    int wait_cycles;
    clk_out    = 1'b0;
    frame_tick = 1'b0;
    buttons1   = '0;
    buttons2   = '0;
    x1         = '0;
    y1         = '0;
    x2         = '0;
    y2         = '0;
    col        = '0;
    row        = '0;
    errors     = 0;
    checks     = 0;
    build_table();
    wait_cycles = 0;
    while (rst_n !== 1'b1 && wait_cycles < 10) begin
      @(posedge clk_out);
      wait_cycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("Reset was not released within %0d cycles", wait_cycles);
      $display("Simulation failed");
      $finish;
    end else begin
      apply_steps();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
        $display("Simulation completed successfully");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

endmodule

// File: fight_core.sv
module fight_core import fight_pkg::*; #(
  parameter int ATTACK_FRAMES  = 8,
  parameter int HITSTUN_FRAMES = 10,
  parameter int HIT_DAMAGE     = 12,
  parameter int CHAR_W         = 46,
  parameter int CHAR_H         = 60
) (
  input  logic         clk_out,
  input  logic         rst_n,
  input  logic         frame_tick,
  input  buttons_t     buttons1,
  input  buttons_t     buttons2,
  input  coord_t       x1,
  input  coord_t       y1,
  input  coord_t       x2,
  input  coord_t       y2,
  input  coord_t       col,
  input  coord_t       row,
  output match_state_t match_state,
  output damage_t      damage1,
  output damage_t      damage2,
  output stock_t       stocks1,
  output stock_t       stocks2,
  output rgb_t         hud_rgb
);

  logic        game_tick;
  logic        new_match;
  logic        strike1;
  logic        strike2;
  logic        stun_active1;
  logic        stun_active2;
  logic        got_hit1;
  logic        got_hit2;
  logic        overlap;
  logic [10:0] x1_end;
  logic [10:0] x2_end;
  logic [10:0] y1_end;
  logic [10:0] y2_end;

  // Box far edges, one extra bit so the right edge of the screen cannot wrap
  assign x1_end = {1'b0, x1} + 11'(CHAR_W);
  assign x2_end = {1'b0, x2} + 11'(CHAR_W);
  assign y1_end = {1'b0, y1} + 11'(CHAR_H);
  assign y2_end = {1'b0, y2} + 11'(CHAR_H);

  assign overlap = ({1'b0, x1} < x2_end) && ({1'b0, x2} < x1_end) &&
                   ({1'b0, y1} < y2_end) && ({1'b0, y2} < y1_end);

  // A strike lands on the opponent only when in reach and not already stunned
  assign got_hit2 = strike1 && overlap && !stun_active2;
  assign got_hit1 = strike2 && overlap && !stun_active1;

  match_fsm match_fsm_inst (
    .clk_out    (clk_out),
    .rst_n      (rst_n),
    .frame_tick (frame_tick),
    .buttons1   (buttons1),
    .buttons2   (buttons2),
    .stocks1    (stocks1),
    .stocks2    (stocks2),
    .match_state(match_state),
    .game_tick  (game_tick),
    .new_match  (new_match)
  );

  attack_decode #(.ATTACK_FRAMES(ATTACK_FRAMES)) attack_decode1_inst (
    .clk_out   (clk_out),
    .rst_n     (rst_n),
    .game_tick (game_tick),
    .new_match (new_match),
    .attack_btn(buttons1[BTN_A]),
    .strike    (strike1)
  );

  attack_decode #(.ATTACK_FRAMES(ATTACK_FRAMES)) attack_decode2_inst (
    .clk_out   (clk_out),
    .rst_n     (rst_n),
    .game_tick (game_tick),
    .new_match (new_match),
    .attack_btn(buttons2[BTN_A]),
    .strike    (strike2)
  );

  hit_tracker #(
    .HITSTUN_FRAMES(HITSTUN_FRAMES),
    .HIT_DAMAGE    (HIT_DAMAGE)
  ) hit_tracker1_inst (
    .clk_out    (clk_out),
    .rst_n      (rst_n),
    .game_tick  (game_tick),
    .new_match  (new_match),
    .got_hit    (got_hit1),
    .damage     (damage1),
    .stocks     (stocks1),
    .stun_active(stun_active1)
  );

  hit_tracker #(
    .HITSTUN_FRAMES(HITSTUN_FRAMES),
    .HIT_DAMAGE    (HIT_DAMAGE)
  ) hit_tracker2_inst (
    .clk_out    (clk_out),
    .rst_n      (rst_n),
    .game_tick  (game_tick),
    .new_match  (new_match),
    .got_hit    (got_hit2),
    .damage     (damage2),
    .stocks     (stocks2),
    .stun_active(stun_active2)
  );

  hud_overlay hud_overlay_inst (
    .col        (col),
    .row        (row),
    .match_state(match_state),
    .damage1    (damage1),
    .damage2    (damage2),
    .stocks1    (stocks1),
    .stocks2    (stocks2),
    .hud_rgb    (hud_rgb)
  );

endmodule

// File: hud_overlay.sv
module hud_overlay import fight_pkg::*; (
  input  coord_t       col,
  input  coord_t       row,
  input  match_state_t match_state,
  input  damage_t      damage1,
  input  damage_t      damage2,
  input  stock_t       stocks1,
  input  stock_t       stocks2,
  output rgb_t         hud_rgb
);

  localparam coord_t OUTLINE_W   = BAR_WIDTH + 10'd4;
  localparam coord_t OUTLINE_H   = BAR_HEIGHT + 10'd4;
  localparam coord_t FILL_INSET  = 10'd2;
  localparam coord_t STOCK_Y     = BAR_Y + 10'd23;
  localparam coord_t STOCK_SIZE  = 10'd10;
  localparam coord_t STOCK_PITCH = 10'd15;

  // Colour of one player's bar and stocks, drawn is low outside them
  function automatic rgb_t player_pixel(
    input  coord_t  px,
    input  coord_t  py,
    input  coord_t  bar_x,
    input  damage_t dmg,
    input  stock_t  stk,
    input  rgb_t    colour,
    output logic    drawn
  );
    coord_t fill_w;
    coord_t sq_x;
    logic   in_outline;
    logic   in_fill;
    logic   in_stock;
    fill_w     = BAR_WIDTH - coord_t'(dmg);
    in_outline = (px >= bar_x) && (px < bar_x + OUTLINE_W) &&
                 (py >= BAR_Y) && (py < BAR_Y + OUTLINE_H);
    in_fill    = (px >= bar_x + FILL_INSET) && (px < bar_x + FILL_INSET + fill_w) &&
                 (py >= BAR_Y + FILL_INSET) && (py < BAR_Y + FILL_INSET + BAR_HEIGHT);
    in_stock   = 1'b0;
    for (int i = 0; i < START_STOCKS; i++) begin
      sq_x = bar_x + coord_t'(i) * STOCK_PITCH;
      if ((stk > stock_t'(i)) && (px >= sq_x) && (px < sq_x + STOCK_SIZE) &&
          (py >= STOCK_Y) && (py < STOCK_Y + STOCK_SIZE)) begin
        in_stock = 1'b1;
      end
    end
    drawn = in_outline || in_stock;
    // Fill sits on top of the outline
    if (in_fill || in_stock) begin
      return colour;
    end else if (in_outline) begin
      return RGB_WHITE;
    end
    return RGB_BLACK;
  endfunction

  rgb_t p1_rgb;
  rgb_t p2_rgb;
  logic p1_drawn;
  logic p2_drawn;

  always_comb begin
    p1_rgb = player_pixel(col, row, P1_BAR_X, damage1, stocks1, RGB_GREEN, p1_drawn);
    p2_rgb = player_pixel(col, row, P2_BAR_X, damage2, stocks2, RGB_RED, p2_drawn);
    if (match_state == MATCH_START) begin
      hud_rgb = RGB_BLACK;
    end else if (p1_drawn) begin
      hud_rgb = p1_rgb;
    end else if (p2_drawn) begin
      hud_rgb = p2_rgb;
    end else begin
      hud_rgb = RGB_BLACK;
    end
  end

endmodule

// File: match_fsm.sv
module match_fsm import fight_pkg::*; (
  input  logic         clk_out,
  input  logic         rst_n,
  input  logic         frame_tick,
  input  buttons_t     buttons1,
  input  buttons_t     buttons2,
  input  stock_t       stocks1,
  input  stock_t       stocks2,
  output match_state_t match_state,
  output logic         game_tick,
  output logic         new_match
);

  match_state_t next_state;
  logic         start_valid;
  logic         any_out;

  // All ones means a pad that is unplugged or glitching
  assign start_valid = (buttons1[BTN_START] && (buttons1 != '1)) ||
                       (buttons2[BTN_START] && (buttons2 != '1));
  assign any_out     = (stocks1 == '0) || (stocks2 == '0);

  always_comb begin
    next_state = match_state;
    case (match_state)
      MATCH_START: begin
        if (start_valid) begin
          next_state = MATCH_PLAYING;
        end
      end
      MATCH_PLAYING: begin
        if (any_out) begin
          next_state = MATCH_OVER;
        end
      end
      MATCH_OVER: begin
        if (start_valid) begin
          next_state = MATCH_PLAYING;
        end
      end
      default: next_state = MATCH_START;
    endcase
  end

  always_ff @(posedge clk_out or negedge rst_n) begin
    if (!rst_n) begin
      match_state <= MATCH_START;
    end else begin
      match_state <= next_state;
    end
  end

  // Pulse in the cycle before play begins
  assign new_match = (match_state != MATCH_PLAYING) && (next_state == MATCH_PLAYING);
  assign game_tick = frame_tick && (match_state == MATCH_PLAYING);

endmodule

// File: hit_tracker.sv
module hit_tracker import fight_pkg::*; #(
  parameter int HITSTUN_FRAMES = 10,
  parameter int HIT_DAMAGE     = 12
) (
  input  logic    clk_out,
  input  logic    rst_n,
  input  logic    game_tick,
  input  logic    new_match,
  input  logic    got_hit,
  output damage_t damage,
  output stock_t  stocks,
  output logic    stun_active
);

  localparam int STUN_W = $clog2(HITSTUN_FRAMES + 1);

  logic [STUN_W-1:0] stun_cnt;
  logic [7:0]        damage_sum;
  logic              knocked_out;

  // One spare bit so the sum cannot wrap
  assign damage_sum  = {1'b0, damage} + 8'(HIT_DAMAGE);
  assign knocked_out = damage_sum >= {1'b0, DAMAGE_KO};
  assign stun_active = stun_cnt != '0;

  always_ff @(posedge clk_out or negedge rst_n) begin
    if (!rst_n) begin
      damage   <= '0;
      stocks   <= START_STOCKS;
      stun_cnt <= '0;
    end else if (new_match) begin
      damage   <= '0;
      stocks   <= START_STOCKS;
      stun_cnt <= '0;
    end else if (got_hit) begin
      stun_cnt <= STUN_W'(HITSTUN_FRAMES);
      if (knocked_out) begin
        // KO resets the meter and costs a life
        damage <= '0;
        if (stocks != '0) begin
          stocks <= stocks - 1'b1;
        end
      end else begin
        damage <= damage_sum[6:0];
      end
    end else if (game_tick && stun_active) begin
      stun_cnt <= stun_cnt - 1'b1;
    end
  end

  a_damage_below_ko : assert property (
    @(posedge clk_out) disable iff (!rst_n) damage < DAMAGE_KO
  );

  // Top level must mask hits on a stunned player
  a_no_hit_in_stun : assert property (
    @(posedge clk_out) disable iff (!rst_n) got_hit |-> !stun_active
  );

endmodule

// File: attack_decode.sv
module attack_decode #(
  parameter int ATTACK_FRAMES = 8
) (
  input  logic clk_out,
  input  logic rst_n,
  input  logic game_tick,
  input  logic new_match,
  input  logic attack_btn,
  output logic strike
);

  localparam int CNT_W = $clog2(ATTACK_FRAMES + 1);

  logic             btn_prev;
  logic [CNT_W-1:0] cooldown;
  logic             fresh_press;

  // Rising edge seen across two game ticks, only when ready
  assign fresh_press = game_tick && attack_btn && !btn_prev && (cooldown == '0);

  always_ff @(posedge clk_out or negedge rst_n) begin
    if (!rst_n) begin
      btn_prev <= 1'b0;
      cooldown <= '0;
      strike   <= 1'b0;
    end else if (new_match) begin
      btn_prev <= 1'b0;
      cooldown <= '0;
      strike   <= 1'b0;
    end else begin
      strike <= fresh_press;
      if (game_tick) begin
        btn_prev <= attack_btn;
        if (fresh_press) begin
          cooldown <= CNT_W'(ATTACK_FRAMES);
        end else if (cooldown != '0) begin
          cooldown <= cooldown - 1'b1;
        end
      end
    end
  end

  // One strike per press, never a held pulse
  a_strike_single : assert property (
    @(posedge clk_out) disable iff (!rst_n) strike |=> !strike
  );

endmodule

// File: fight_pkg.sv
package fight_pkg;

  // Widths that carry a meaning
  typedef logic [9:0] coord_t;
  typedef logic [5:0] rgb_t;
  typedef logic [6:0] damage_t;
  typedef logic [1:0] stock_t;
  typedef logic [7:0] buttons_t;

  typedef enum logic [1:0] {
    MATCH_START,
    MATCH_PLAYING,
    MATCH_OVER
  } match_state_t;

  // Bit positions in the decoded gamepad vector
  localparam int BTN_A      = 0;
  localparam int BTN_B      = 1;
  localparam int BTN_SELECT = 2;
  localparam int BTN_START  = 3;
  localparam int BTN_UP     = 4;
  localparam int BTN_DOWN   = 5;
  localparam int BTN_LEFT   = 6;
  localparam int BTN_RIGHT  = 7;

  // A stock is lost once damage reaches this
  localparam damage_t DAMAGE_KO    = 7'd100;
  localparam stock_t  START_STOCKS = 2'd3;

  // Two bits each, red green blue
  localparam rgb_t RGB_WHITE = 6'b111111;
  localparam rgb_t RGB_GREEN = 6'b001100;
  localparam rgb_t RGB_RED   = 6'b110000;
  localparam rgb_t RGB_BLACK = 6'b000000;

  // HUD geometry in pixels
  localparam coord_t BAR_Y      = 10'd10;
  localparam coord_t BAR_WIDTH  = 10'd100;
  localparam coord_t BAR_HEIGHT = 10'd15;
  localparam coord_t P1_BAR_X   = 10'd20;
  localparam coord_t P2_BAR_X   = 10'd520;

endpackage
